//--- Makefile
# Verilator build and run of the I2C master testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module i2c_master_tb -o sim

run: compile
	@out="$$(./obj_dir/sim +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

//--- src.f
+incdir+src
src/i2c_pkg.sv
src/i2c_byte_fifo.sv
src/i2c_scl_timer.sv
src/i2c_bit_shifter.sv
src/i2c_master_ctrl.sv
src/i2c_master_top.sv
verif/i2c_slave_model.sv
verif/i2c_master_checker.sv
verif/i2c_master_tb.sv

//--- src/i2c_bit_shifter.sv
`timescale 1ns/1ns
`include "i2c_settings.svh"

module i2c_bit_shifter (
    input  logic                   i2c_core_clock_i,
    input  logic                   reset_bit_n_i,
    input  i2c_pkg::i2c_bit_op_t   bit_op_i,
    input  i2c_pkg::i2c_tick_t     tick_i,
    input  logic                   load_byte_i,
    input  logic [`I2C_BYTE_W-1:0] load_value_i,
    input  logic                   sda_i,
    output logic                   sda_low_o,
    output logic                   op_done_o,
    output logic                   ack_nack_o,
    output logic [`I2C_BYTE_W-1:0] rx_byte_o
);
    import i2c_pkg::*;

    localparam int BIT_W = $clog2(`I2C_BYTE_W);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`I2C_BYTE_W - 1);

    logic [`I2C_BYTE_W-1:0] shreg_q;
    logic [BIT_W-1:0]       bit_cnt_q;
    logic                   ack_nack_q;
    logic                   multi_bit;
    logic                   sample;
    logic                   bit_end;

    assign multi_bit = (bit_op_i == OP_WRITE) || (bit_op_i == OP_READ);
    assign sample    = tick_i.quarter_end && (tick_i.quarter == 2'd1);   // scl high mid bit
    assign bit_end   = tick_i.quarter_end && (tick_i.quarter == 2'd3);
    // quarter_end only fires while an operation runs
    assign op_done_o = bit_end && (!multi_bit || (bit_cnt_q == LAST_BIT));

    // --------------------
    // byte and bit count
    // --------------------
    always_ff @(posedge i2c_core_clock_i) begin
        if (load_byte_i) begin
            shreg_q <= load_value_i;
        end else if ((bit_op_i == OP_READ) && sample) begin
            shreg_q <= {shreg_q[`I2C_BYTE_W-2:0], sda_i};          // msb first
        end else if ((bit_op_i == OP_WRITE) && bit_end) begin
            shreg_q <= {shreg_q[`I2C_BYTE_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_n_i) begin
        if (!reset_bit_n_i) begin
            bit_cnt_q  <= '0;
            ack_nack_q <= 1'b0;
        end else begin
            if (load_byte_i) begin
                bit_cnt_q <= '0;
            end else if (multi_bit && bit_end) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;                     // wraps after the last bit
            end
            if ((bit_op_i == OP_ACK_IN) && sample) begin
                ack_nack_q <= sda_i;                               // high means nack
            end
        end
    end

    // sda drive, changes only as a quarter begins
    always_comb begin
        case (bit_op_i)
            OP_START:   sda_low_o = (tick_i.quarter != 2'd0);      // falls with scl high
            OP_STOP:    sda_low_o = (tick_i.quarter < 2'd2);       // rises with scl high
            OP_WRITE:   sda_low_o = ~shreg_q[`I2C_BYTE_W-1];
            OP_ACK_OUT: sda_low_o = 1'b1;
            default:    sda_low_o = 1'b0;                          // released
        endcase
    end

    assign ack_nack_o = ack_nack_q;
    assign rx_byte_o  = shreg_q;

endmodule

//--- src/i2c_byte_fifo.sv
`timescale 1ns/1ns
`include "i2c_settings.svh"

module i2c_byte_fifo #(
    parameter type payload_t = logic [`I2C_BYTE_W-1:0]
) (
    input  logic     i2c_core_clock_i,
    input  logic     reset_bit_n_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t head_o,
    output logic     empty_o,
    output logic     full_o,
    output logic     full_next_o
);
    localparam int DEPTH = `I2C_FIFO_DEPTH;
    localparam int PTR_W = ($clog2(DEPTH) > 0) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i && !full_o;             // push to a full FIFO is dropped
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_n_i) begin
        if (!reset_bit_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge i2c_core_clock_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    assign head_o      = mem[rd_ptr_q];
    assign empty_o     = (count_q == '0);
    assign full_o      = (count_q == CNT_W'(DEPTH));
    assign full_next_o = (count_q == CNT_W'(DEPTH - 1));   // one slot left

endmodule

//--- src/i2c_master_ctrl.sv
`timescale 1ns/1ns
`include "i2c_settings.svh"

module i2c_master_ctrl (
    input  logic                   i2c_core_clock_i,
    input  logic                   reset_bit_n_i,
    input  i2c_pkg::i2c_cmd_t      cmd_i,
    input  logic                   cmd_valid_i,
    input  logic                   op_done_i,
    input  logic                   ack_nack_i,
    input  logic [`I2C_BYTE_W-1:0] rx_byte_i,
    input  i2c_pkg::i2c_tx_entry_t tx_head_i,
    input  logic                   tx_empty_i,
    input  logic                   rx_count_full_next_i,
    output i2c_pkg::i2c_bit_op_t   bit_op_o,
    output logic                   load_byte_o,
    output logic [`I2C_BYTE_W-1:0] load_value_o,
    output logic                   tx_pop_o,
    output logic                   rx_push_o,
    output i2c_pkg::i2c_rx_entry_t rx_entry_o,
    output i2c_pkg::i2c_status_t   status_o
);
    import i2c_pkg::*;

    i2c_bit_op_t bit_op_q;
    i2c_bit_op_t bit_op_d;
    i2c_cmd_t    cmd_q;
    logic        addr_phase_q;                      // the pending ack belongs to the address
    logic        addr_phase_d;
    logic        addr_nack_q;
    logic        addr_nack_d;
    logic        data_nack_q;
    logic        data_nack_d;
    logic        done_q;
    logic        start_cmd;

    assign start_cmd = cmd_valid_i && (bit_op_q == OP_IDLE);   // ignored while busy

    // --------------------
    // next operation
    // --------------------
    always_comb begin
        bit_op_d     = bit_op_q;
        addr_phase_d = addr_phase_q;
        addr_nack_d  = addr_nack_q;
        data_nack_d  = data_nack_q;
        load_byte_o  = 1'b0;
        load_value_o = tx_head_i.data;
        tx_pop_o     = 1'b0;
        rx_push_o    = 1'b0;
        case (bit_op_q)
            OP_IDLE: begin
                if (start_cmd) begin
                    bit_op_d    = OP_START;
                    addr_nack_d = 1'b0;             // flags describe the new transaction
                    data_nack_d = 1'b0;
                end
            end
            OP_START: begin
                if (op_done_i) begin
                    bit_op_d     = OP_WRITE;
                    addr_phase_d = 1'b1;
                    load_byte_o  = 1'b1;
                    load_value_o = {cmd_q.addr, cmd_q.rw};
                end
            end
            OP_WRITE: begin
                if (op_done_i) begin
                    bit_op_d = OP_ACK_IN;
                end
            end
            OP_ACK_IN: begin
                if (op_done_i) begin
                    addr_phase_d = 1'b0;
                    if (ack_nack_i) begin
                        bit_op_d = OP_STOP;
                        if (addr_phase_q) begin
                            addr_nack_d = 1'b1;
                        end else begin
                            data_nack_d = 1'b1;
                        end
                    end else if (addr_phase_q && cmd_q.rw) begin
                        bit_op_d = OP_READ;
                    end else if (tx_empty_i) begin
                        bit_op_d = OP_STOP;          // nothing left to send
                    end else begin
                        bit_op_d    = OP_WRITE;
                        load_byte_o = 1'b1;
                        tx_pop_o    = 1'b1;
                    end
                end
            end
            OP_READ: begin
                if (op_done_i) begin
                    rx_push_o = 1'b1;
                    // nack the byte that fills the rx FIFO
                    bit_op_d  = rx_count_full_next_i ? OP_NACK_OUT : OP_ACK_OUT;
                end
            end
            OP_ACK_OUT: begin
                if (op_done_i) begin
                    bit_op_d = OP_READ;
                end
            end
            OP_NACK_OUT: begin
                if (op_done_i) begin
                    bit_op_d = OP_STOP;
                end
            end
            OP_STOP: begin
                if (op_done_i) begin
                    bit_op_d = OP_IDLE;
                end
            end
            default: begin
                bit_op_d = OP_IDLE;
            end
        endcase
    end

    // --------------------
    // state registers
    // --------------------
    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_n_i) begin
        if (!reset_bit_n_i) begin
            bit_op_q     <= OP_IDLE;
            addr_phase_q <= 1'b0;
            addr_nack_q  <= 1'b0;
            data_nack_q  <= 1'b0;
            done_q       <= 1'b0;
        end else begin
            bit_op_q     <= bit_op_d;
            addr_phase_q <= addr_phase_d;
            addr_nack_q  <= addr_nack_d;
            data_nack_q  <= data_nack_d;
            done_q       <= (bit_op_q == OP_STOP) && op_done_i;   // as busy falls
        end
    end

    always_ff @(posedge i2c_core_clock_i) begin
        if (start_cmd) begin
            cmd_q <= cmd_i;                          // held for the whole transaction
        end
    end

    assign bit_op_o   = bit_op_q;
    assign rx_entry_o = '{data: rx_byte_i, last: rx_count_full_next_i};
    assign status_o   = '{busy:      (bit_op_q != OP_IDLE),
                          addr_nack: addr_nack_q,
                          data_nack: data_nack_q,
                          done:      done_q};

endmodule

//--- src/i2c_master_top.sv
`timescale 1ns/1ns
`include "i2c_settings.svh"

module i2c_master_top (
    input  logic                   i2c_core_clock_i,
    input  logic                   reset_bit_n_i,
    input  i2c_pkg::i2c_cmd_t      cmd_i,
    input  logic                   cmd_valid_i,
    input  logic                   tx_push_i,
    input  i2c_pkg::i2c_tx_entry_t tx_data_i,
    input  logic                   rx_pop_i,
    input  logic                   sda_i,            // resolved sda level
    input  logic                   scl_i,            // resolved scl level
    output logic                   tx_full_o,
    output logic                   tx_empty_o,
    output i2c_pkg::i2c_rx_entry_t rx_data_o,
    output logic                   rx_empty_o,
    output i2c_pkg::i2c_status_t   status_o,
    output logic                   sda_low_o,
    output logic                   scl_low_o
);
    import i2c_pkg::*;

    i2c_bit_op_t            bit_op;
    i2c_tick_t              tick;
    logic                   load_byte;
    logic [`I2C_BYTE_W-1:0] load_value;
    logic                   op_done;
    logic                   ack_nack;
    logic [`I2C_BYTE_W-1:0] rx_byte;
    i2c_tx_entry_t          tx_head;
    logic                   tx_pop;
    logic                   rx_push;
    i2c_rx_entry_t          rx_entry;
    logic                   rx_full_next;

    // --------------------
    // control
    // --------------------
    i2c_master_ctrl u_ctrl (
        .i2c_core_clock_i     (i2c_core_clock_i),
        .reset_bit_n_i        (reset_bit_n_i),
        .cmd_i                (cmd_i),
        .cmd_valid_i          (cmd_valid_i),
        .op_done_i            (op_done),
        .ack_nack_i           (ack_nack),
        .rx_byte_i            (rx_byte),
        .tx_head_i            (tx_head),
        .tx_empty_i           (tx_empty_o),
        .rx_count_full_next_i (rx_full_next),
        .bit_op_o             (bit_op),
        .load_byte_o          (load_byte),
        .load_value_o         (load_value),
        .tx_pop_o             (tx_pop),
        .rx_push_o            (rx_push),
        .rx_entry_o           (rx_entry),
        .status_o             (status_o)
    );

    // --------------------
    // bit level datapath
    // --------------------
    i2c_scl_timer u_timer (
        .i2c_core_clock_i (i2c_core_clock_i),
        .reset_bit_n_i    (reset_bit_n_i),
        .bit_op_i         (bit_op),
        .tick_o           (tick),
        .scl_low_o        (scl_low_o)
    );

    i2c_bit_shifter u_shifter (
        .i2c_core_clock_i (i2c_core_clock_i),
        .reset_bit_n_i    (reset_bit_n_i),
        .bit_op_i         (bit_op),
        .tick_i           (tick),
        .load_byte_i      (load_byte),
        .load_value_i     (load_value),
        .sda_i            (sda_i),
        .sda_low_o        (sda_low_o),
        .op_done_o        (op_done),
        .ack_nack_o       (ack_nack),
        .rx_byte_o        (rx_byte)
    );

    // --------------------
    // byte FIFOs
    // --------------------
    i2c_byte_fifo #(.payload_t(i2c_tx_entry_t)) tx_fifo (
        .i2c_core_clock_i (i2c_core_clock_i),
        .reset_bit_n_i    (reset_bit_n_i),
        .push_i           (tx_push_i),
        .push_data_i      (tx_data_i),
        .pop_i            (tx_pop),
        .head_o           (tx_head),
        .empty_o          (tx_empty_o),
        .full_o           (tx_full_o),
        .full_next_o      ()
    );

    i2c_byte_fifo #(.payload_t(i2c_rx_entry_t)) rx_fifo (
        .i2c_core_clock_i (i2c_core_clock_i),
        .reset_bit_n_i    (reset_bit_n_i),
        .push_i           (rx_push),
        .push_data_i      (rx_entry),
        .pop_i            (rx_pop_i),
        .head_o           (rx_data_o),
        .empty_o          (rx_empty_o),
        .full_o           (),
        .full_next_o      (rx_full_next)             // this push fills the rx FIFO
    );

endmodule

//--- src/i2c_pkg.sv
`include "i2c_settings.svh"

package i2c_pkg;

    typedef struct packed {
        logic [6:0] addr;                         // 7-bit slave address
        logic       rw;                           // 1 = read, 0 = write
    } i2c_cmd_t;

    typedef struct packed {
        logic busy;                               // transaction in progress
        logic addr_nack;                          // slave did not ack its address
        logic data_nack;                          // slave nacked a written byte
        logic done;                               // one-cycle end of transaction
    } i2c_status_t;

    typedef enum logic [2:0] {
        OP_IDLE, OP_START, OP_WRITE, OP_READ,
        OP_ACK_IN, OP_ACK_OUT, OP_NACK_OUT, OP_STOP
    } i2c_bit_op_t;

    typedef struct packed {
        logic [1:0] quarter;                      // quarter of the current bit
        logic       quarter_end;                  // last core clock of the quarter
    } i2c_tick_t;

    typedef struct packed {
        logic [`I2C_BYTE_W-1:0] data;
    } i2c_tx_entry_t;

    typedef struct packed {
        logic [`I2C_BYTE_W-1:0] data;
        logic                   last;             // byte the master nacked
    } i2c_rx_entry_t;

endpackage

//--- src/i2c_scl_timer.sv
`timescale 1ns/1ns
`include "i2c_settings.svh"

module i2c_scl_timer (
    input  logic                 i2c_core_clock_i,
    input  logic                 reset_bit_n_i,
    input  i2c_pkg::i2c_bit_op_t bit_op_i,
    output i2c_pkg::i2c_tick_t   tick_o,
    output logic                 scl_low_o
);
    import i2c_pkg::*;

    localparam int CNT_W = ($clog2(`I2C_QUARTER_CLKS) > 0) ? $clog2(`I2C_QUARTER_CLKS) : 1;
    localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(`I2C_QUARTER_CLKS - 1);

    logic [CNT_W-1:0] clk_cnt_q;
    logic [1:0]       quarter_q;
    logic             running;
    logic             quarter_end;

    assign running     = (bit_op_i != OP_IDLE);
    assign quarter_end = running && (clk_cnt_q == LAST_CLK);

    always_ff @(posedge i2c_core_clock_i or negedge reset_bit_n_i) begin
        if (!reset_bit_n_i) begin
            clk_cnt_q <= '0;
            quarter_q <= 2'd0;
        end else if (!running) begin
            clk_cnt_q <= '0;                        // next op starts at quarter 0
            quarter_q <= 2'd0;
        end else if (quarter_end) begin
            clk_cnt_q <= '0;
            quarter_q <= quarter_q + 2'd1;          // wraps after quarter 3
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
    end

    // scl pattern per operation
    always_comb begin
        case (bit_op_i)
            OP_IDLE:  scl_low_o = 1'b0;                          // bus released
            OP_START: scl_low_o = (quarter_q == 2'd3);
            OP_STOP:  scl_low_o = (quarter_q == 2'd0);
            default:  scl_low_o = (quarter_q == 2'd0) || (quarter_q == 2'd3);
        endcase
    end

    assign tick_o = '{quarter: quarter_q, quarter_end: quarter_end};

endmodule

//--- src/i2c_settings.svh
`ifndef I2C_SETTINGS_SVH
`define I2C_SETTINGS_SVH

// --------------------
// bus timing
// --------------------
// core clocks per quarter of an scl bit
`define I2C_QUARTER_CLKS 5

// --------------------
// datapath sizes
// --------------------
// entries in each of the tx and rx FIFOs
`define I2C_FIFO_DEPTH 4
// bits per byte on the bus
`define I2C_BYTE_W 8

`endif

//--- verif/i2c_golden.txt
# id addr rw nack_pos count byte0 byte1 byte2 byte3 (addr and bytes in hex)
# nack_pos is the data byte the slave nacks, 0 for none; unused bytes are 00
1 50 0 0 3 a5 3c 0f 00
2 51 0 0 2 11 22 00 00
3 50 0 2 2 33 44 00 00
4 50 0 0 1 55 00 00 00
5 50 1 0 4 c3 5a 81 7e
6 51 1 0 4 00 00 00 00
7 50 0 4 4 01 80 ff 00
8 50 0 0 0 00 00 00 00
9 50 1 0 4 96 69 e1 1e

//--- verif/i2c_master_checker.sv
`timescale 1ns/1ns

module i2c_master_checker (
    input logic                 i2c_core_clock_i,
    input logic                 reset_bit_n_i,
    input i2c_pkg::i2c_bit_op_t bit_op_i,
    input i2c_pkg::i2c_status_t status_i,
    input logic                 sda_i,
    input logic                 scl_i
);
    import i2c_pkg::*;

    int   fail_cnt = 0;
    logic edge_op;

    assign edge_op = (bit_op_i == OP_START) || (bit_op_i == OP_STOP);   // sda moves with scl high

    // --------------------
    // bus protocol
    // --------------------
    sda_stable: assert property (@(posedge i2c_core_clock_i) disable iff (!reset_bit_n_i)
        (scl_i && $past(scl_i) && !edge_op && !$past(edge_op)) |-> $stable(sda_i))
        else begin
            fail_cnt++;
            $error("sda changed while scl was high outside start and stop");
        end

    done_single: assert property (@(posedge i2c_core_clock_i) disable iff (!reset_bit_n_i)
        status_i.done |=> !status_i.done)
        else begin
            fail_cnt++;
            $error("done held for more than one cycle");
        end

    done_idle: assert property (@(posedge i2c_core_clock_i) disable iff (!reset_bit_n_i)
        status_i.done |-> !status_i.busy)
        else begin
            fail_cnt++;
            $error("done fired while busy was high");
        end

endmodule

//--- verif/i2c_master_tb.sv
`timescale 1ns/1ns
`include "i2c_settings.svh"

module i2c_master_tb;
    import i2c_pkg::*;

    localparam logic [6:0] SLAVE_ADDR = 7'h50;
    localparam int         CLK_NS     = 40;
    localparam int         DEPTH      = `I2C_FIFO_DEPTH;
    localparam int         MAX_TESTS  = 16;

    logic          clk;
    logic          rst_n;
    i2c_cmd_t      cmd;
    logic          cmd_valid;
    logic          tx_push;
    i2c_tx_entry_t tx_data;
    logic          rx_pop;
    logic          sda;
    logic          scl;
    logic          tx_full;
    logic          tx_empty;
    i2c_rx_entry_t rx_data;
    logic          rx_empty;
    i2c_status_t   status;
    logic          sda_low;
    logic          scl_low;
    logic [7:0]    nack_pos;
    logic [31:0]   rd_data;

    int          t_id [MAX_TESTS];
    logic [6:0]  t_addr [MAX_TESTS];
    logic        t_rw [MAX_TESTS];
    int          t_nack [MAX_TESTS];
    int          t_cnt [MAX_TESTS];
    logic [31:0] t_bytes [MAX_TESTS];              // byte 0 in the top byte
    int          n_tests = 0;
    int          errors = 0;
    int          failed_tests = 0;
    int          done_cnt = 0;
    longint      watchdog_ns = 0;
    logic [7:0]  tx_model [$];                     // bytes expected in the tx FIFO

    i2c_master_top UUT (
        .i2c_core_clock_i (clk),
        .reset_bit_n_i    (rst_n),
        .cmd_i            (cmd),
        .cmd_valid_i      (cmd_valid),
        .tx_push_i        (tx_push),
        .tx_data_i        (tx_data),
        .rx_pop_i         (rx_pop),
        .sda_i            (sda),
        .scl_i            (scl),
        .tx_full_o        (tx_full),
        .tx_empty_o       (tx_empty),
        .rx_data_o        (rx_data),
        .rx_empty_o       (rx_empty),
        .status_o         (status),
        .sda_low_o        (sda_low),
        .scl_low_o        (scl_low)
    );

    i2c_slave_model u_slave (
        .sda_low_m_i (sda_low),
        .scl_low_m_i (scl_low),
        .own_addr_i  (SLAVE_ADDR),
        .nack_pos_i  (nack_pos),
        .rd_data_i   (rd_data),
        .sda_o       (sda),
        .scl_o       (scl)
    );

    bind i2c_master_top i2c_master_checker u_checker (
        .i2c_core_clock_i (i2c_core_clock_i),
        .reset_bit_n_i    (reset_bit_n_i),
        .bit_op_i         (bit_op),
        .status_i         (status_o),
        .sda_i            (sda_i),
        .scl_i            (scl_i)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(negedge clk) begin
        if (status.done) begin
            done_cnt++;                            // strobe is stable mid cycle
        end
    end

    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("watchdog: run still going after %0d ns", watchdog_ns);
        $display("Testbench failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t ns %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // --------------------
    // golden file
    // --------------------
    task automatic load_golden();
        int               fd;
        int               n;
        int               id;
        int               rw;
        int               np;
        int               cnt;
        logic [7:0]       ad;
        logic [7:0]       b0;
        logic [7:0]       b1;
        logic [7:0]       b2;
        logic [7:0]       b3;
        logic [8*128-1:0] line;
        fd = $fopen("verif/i2c_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/i2c_golden.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%d %h %d %d %d %h %h %h %h",
                            id, ad, rw, np, cnt, b0, b1, b2, b3);
                if (n == 9) begin                  // comment and blank lines do not match
                    t_id[n_tests]    = id;
                    t_addr[n_tests]  = ad[6:0];
                    t_rw[n_tests]    = rw[0];
                    t_nack[n_tests]  = np;
                    t_cnt[n_tests]   = cnt;
                    t_bytes[n_tests] = {b0, b1, b2, b3};
                    n_tests++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic push_bytes(input int k);
        int i;
        for (i = 0; i < t_cnt[k]; i++) begin
            check_value("tx_full_o", tx_full, tx_model.size() == DEPTH);
            if (!tx_full) begin
                tx_data = '{data: t_bytes[k][31 - 8 * i -: 8]};
                tx_push = 1'b1;
                @(negedge clk);
                tx_push = 1'b0;
                tx_model.push_back(t_bytes[k][31 - 8 * i -: 8]);
            end
        end
        check_value("tx_full_o", tx_full, tx_model.size() == DEPTH);
    endtask

    task automatic pop_and_check(input int k);
        int i;
        for (i = 0; i < DEPTH; i++) begin
            check_value("rx_empty_o", rx_empty, 1'b0);
            check_value("rx_data_o.data", rx_data.data, t_bytes[k][31 - 8 * i -: 8]);
            check_value("rx_data_o.last", rx_data.last, i == DEPTH - 1);
            rx_pop = 1'b1;
            @(negedge clk);
            rx_pop = 1'b0;
        end
        check_value("rx_empty_o", rx_empty, 1'b1);
    endtask

    // --------------------
    // one transaction
    // --------------------
    task automatic run_test(input int k);
        int   err_before;
        int   starts_before;
        int   dones_before;
        int   cycles;
        int   limit;
        int   sent;
        int   i;
        logic exp_addr_nack;
        logic exp_data_nack;
        err_before    = errors;
        starts_before = u_slave.start_cnt;
        dones_before  = done_cnt;
        limit         = 2 * (3 + 9 * (DEPTH + 1)) * 4 * `I2C_QUARTER_CLKS;
        nack_pos      = t_nack[k][7:0];
        rd_data       = t_bytes[k];
        if (!t_rw[k]) begin
            push_bytes(k);
        end
        @(negedge clk);
        cmd       = '{addr: t_addr[k], rw: t_rw[k]};
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        check_value("status_o.busy", status.busy, 1'b1);
        repeat (2) @(negedge clk);
        cmd       = '{addr: t_addr[k] ^ 7'h01, rw: !t_rw[k]};   // must be ignored
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        cycles = 0;
        while (!status.done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!status.done) begin
            $display("test %0d: no done strobe within %0d cycles", t_id[k], limit);
            errors++;
        end
        exp_addr_nack = (t_addr[k] != SLAVE_ADDR);
        exp_data_nack = 1'b0;
        sent          = 0;
        if (!exp_addr_nack && !t_rw[k]) begin
            sent = tx_model.size();
            if (t_nack[k] != 0 && t_nack[k] <= sent) begin
                sent          = t_nack[k];
                exp_data_nack = 1'b1;
            end
        end
        check_value("status_o.busy", status.busy, 1'b0);
        check_value("status_o.addr_nack", status.addr_nack, exp_addr_nack);
        check_value("status_o.data_nack", status.data_nack, exp_data_nack);
        check_value("slave address byte", u_slave.addr_seen, {t_addr[k], t_rw[k]});
        if (!t_rw[k]) begin
            check_value("slave byte count", u_slave.wr_cnt, sent);
            for (i = 0; i < sent; i++) begin
                check_value("slave byte", u_slave.wr_log[i], tx_model.pop_front());
            end
            check_value("tx_empty_o", tx_empty, tx_model.size() == 0);
        end else if (!exp_addr_nack) begin
            check_value("slave ack count", u_slave.ack_cnt, DEPTH - 1);
            check_value("slave nack count", u_slave.nack_cnt, 1);
            pop_and_check(k);
        end else begin
            check_value("rx_empty_o", rx_empty, 1'b1);
        end
        repeat (2) @(negedge clk);
        check_value("done pulses", done_cnt - dones_before, 1);
        check_value("slave start count", u_slave.start_cnt - starts_before, 1);
        if (errors == err_before) begin
            $display("test %0d %s addr %02h: pass",
                     t_id[k], t_rw[k] ? "read" : "write", t_addr[k]);
        end else begin
            $display("test %0d %s addr %02h: FAIL",
                     t_id[k], t_rw[k] ? "read" : "write", t_addr[k]);
            failed_tests++;
        end
    endtask

    initial begin
        int k;
        int err_before;
        rst_n     = 1'b0;
        cmd       = '0;
        cmd_valid = 1'b0;
        tx_push   = 1'b0;
        tx_data   = '0;
        rx_pop    = 1'b0;
        nack_pos  = '0;
        rd_data   = '0;
        load_golden();
        watchdog_ns = 8 * CLK_NS;
        for (k = 0; k < n_tests; k++) begin
            watchdog_ns += 2 * (3 + 9 * (t_cnt[k] + 1)) * 4 * `I2C_QUARTER_CLKS * CLK_NS;
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        err_before = errors;
        check_value("status_o.busy", status.busy, 1'b0);
        check_value("scl_low_o", scl_low, 1'b0);
        check_value("sda_low_o", sda_low, 1'b0);
        check_value("tx_empty_o", tx_empty, 1'b1);
        check_value("rx_empty_o", rx_empty, 1'b1);
        if (errors == err_before) begin
            $display("test 0 reset: pass");
        end else begin
            $display("test 0 reset: FAIL");
            failed_tests++;
        end
        for (k = 0; k < n_tests; k++) begin
            run_test(k);
        end
        $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 n_tests + 1, failed_tests, errors, UUT.u_checker.fail_cnt);
        if (errors == 0 && UUT.u_checker.fail_cnt == 0 && n_tests > 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verif/i2c_slave_model.sv
`timescale 1ns/1ns

module i2c_slave_model (
    input  logic        sda_low_m_i,               // master pulls sda low
    input  logic        scl_low_m_i,               // master pulls scl low
    input  logic [6:0]  own_addr_i,
    input  logic [7:0]  nack_pos_i,                // data byte to nack, 0 for none
    input  logic [31:0] rd_data_i,                 // read bytes, first one in the top byte
    output logic        sda_o,                     // resolved bus levels
    output logic        scl_o
);
    logic       sda_drive;
    logic [7:0] addr_seen;
    logic [7:0] wr_log [8];
    int         start_cnt;
    int         wr_cnt;
    int         ack_cnt;                           // master acks seen while reading
    int         nack_cnt;

    assign sda_o = !(sda_low_m_i || sda_drive);    // open drain, either side pulls low
    assign scl_o = !scl_low_m_i;

    // one byte from the master, stop set when sda rises with scl high
    task automatic get_byte(output logic [7:0] data, output logic stop);
        int i;
        stop = 1'b0;
        data = '0;
        for (i = 0; i < 8; i++) begin
            @(posedge scl_o);
            data = {data[6:0], sda_o};
            @(negedge scl_o or posedge sda_o);
            if (scl_o) begin
                stop = 1'b1;
                return;
            end
        end
    endtask

    task automatic send_ack(input logic ack);
        sda_drive = ack;
        @(posedge scl_o);
        @(negedge scl_o);
        sda_drive = 1'b0;
    endtask

    // one byte to the master, then its ack or nack
    task automatic put_byte(input logic [7:0] data, output logic acked);
        int i;
        for (i = 7; i >= 0; i--) begin
            sda_drive = !data[i];
            @(posedge scl_o);
            @(negedge scl_o);
        end
        sda_drive = 1'b0;
        @(posedge scl_o);
        acked = !sda_o;
        @(negedge scl_o);
    endtask

    initial begin
        logic [7:0] data;
        logic       stop;
        logic       acked;
        int         idx;
        sda_drive = 1'b0;
        start_cnt = 0;
        wr_cnt    = 0;
        ack_cnt   = 0;
        nack_cnt  = 0;
        addr_seen = '0;
        forever begin
            @(negedge sda_o);
            if (scl_o) begin                       // start condition
                start_cnt++;
                wr_cnt   = 0;
                ack_cnt  = 0;
                nack_cnt = 0;
                get_byte(addr_seen, stop);
                if (addr_seen[7:1] == own_addr_i) begin
                    send_ack(1'b1);
                    if (addr_seen[0]) begin
                        idx = 0;
                        do begin
                            put_byte(rd_data_i[31 - 8 * (idx % 4) -: 8], acked);
                            if (acked) begin
                                ack_cnt++;
                            end else begin
                                nack_cnt++;
                            end
                            idx++;
                        end while (acked);
                    end else begin
                        stop = 1'b0;
                        while (!stop) begin
                            get_byte(data, stop);
                            if (!stop) begin
                                wr_log[wr_cnt % 8] = data;
                                wr_cnt++;
                                send_ack(wr_cnt != nack_pos_i);
                            end
                        end
                    end
                end
            end
        end
    end

endmodule
